//--- verilog/feistel48_pkg.sv
// Feistel-48 shared widths, types, key derivation constants and the AES S-box
package feistel48_pkg;

    // ============================================================
    // Widths and round count
    // ============================================================
    localparam int ROUNDS  = 48;
    localparam int ROUND_W = 6;
    localparam int BLOCK_W = 128;
    localparam int HALF_W  = 64;
    localparam int KEY_W   = 256;
    localparam int RKEY_W  = 128;

    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [HALF_W-1:0]  half_t;
    typedef logic [KEY_W-1:0]   key_t;
    typedef logic [RKEY_W-1:0]  rkey_t;
    typedef logic [ROUND_W-1:0] round_t;

    // ============================================================
    // Key derivation constants
    // ============================================================
    // Salt is the byte ramp 00..FF over 16 bytes, used twice
    localparam key_t HKDF_SALT = {2{128'h00112233445566778899AABBCCDDEEFF}};

    // Whitening domain separators
    localparam key_t PRE_WHITEN_CONST  = {16{16'hA55A}};
    localparam key_t POST_WHITEN_CONST = {16{16'h5AA5}};

    // Golden ratio constant, 64-bit form and widened for the round multiplier
    localparam half_t PHI_64  = 64'h9E3779B97F4A7C15;
    localparam key_t  PHI_256 = {4{PHI_64}};

    // ============================================================
    // AES forward S-box
    // ============================================================
    // Entry 0 sits at the left end, one table row per line
    localparam logic [0:255][7:0] SBOX_TABLE = {
        64'h637C777BF26B6FC5, 64'h3001672BFED7AB76,
        64'hCA82C97DFA5947F0, 64'hADD4A2AF9CA472C0,
        64'hB7FD9326363FF7CC, 64'h34A5E5F171D83115,
        64'h04C723C31896059A, 64'h071280E2EB27B275,
        64'h09832C1A1B6E5AA0, 64'h523BD6B329E32F84,
        64'h53D100ED20FCB15B, 64'h6ACBBE394A4C58CF,
        64'hD0EFAAFB434D3385, 64'h45F9027F503C9FA8,
        64'h51A3408F929D38F5, 64'hBCB6DA2110FFF3D2,
        64'hCD0C13EC5F974417, 64'hC4A77E3D645D1973,
        64'h60814FDC222A9088, 64'h46EEB814DE5E0BDB,
        64'hE0323A0A4906245C, 64'hC2D3AC629195E479,
        64'hE7C8376D8DD54EA9, 64'h6C56F4EA657AAE08,
        64'hBA78252E1CA6B4C6, 64'hE8DD741F4BBD8B8A,
        64'h703EB5664803F60E, 64'h613557B986C11D9E,
        64'hE1F8981169D98E94, 64'h9B1E87E9CE5528DF,
        64'h8CA1890DBFE64268, 64'h41992D0FB054BB16
    };

    function automatic logic [7:0] aes_sbox(input logic [7:0] byte_in);
        return SBOX_TABLE[byte_in];
    endfunction

endpackage

//--- verilog/feistel48_control.sv
// Feistel-48 sequencer: accepts a start, steps through load, 48 rounds and finish
module feistel48_control
    import feistel48_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start_i,
    output logic   capture_o,
    output logic   load_o,
    output logic   round_en_o,
    output logic   finish_o,
    output round_t round_o,
    output logic   done_o,
    output logic   busy_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_ROUNDS,
        S_FINISH
    } state_t;

    state_t state;
    round_t round_cnt;

    // Start is only taken while idle, key and mode are captured on that edge
    assign capture_o  = (state == S_IDLE) && start_i;
    assign load_o     = (state == S_LOAD);
    assign round_en_o = (state == S_ROUNDS);
    assign finish_o   = (state == S_FINISH);
    assign round_o    = round_cnt;
    assign busy_o     = (state != S_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            round_cnt <= '0;
            done_o    <= 1'b0;
        end else begin
            // Done follows the finish strobe by one cycle
            done_o <= finish_o;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    round_cnt <= '0;
                    state     <= S_ROUNDS;
                end
                S_ROUNDS: begin
                    if (round_cnt == ROUND_W'(ROUNDS - 1)) begin
                        state <= S_FINISH;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/feistel48_key_schedule.sv
// Feistel-48 key schedule: salted key register, on-the-fly round keys, whitening keys
module feistel48_key_schedule
    import feistel48_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   capture_i,
    input  logic   decrypt_i,
    input  key_t   key_i,
    input  round_t round_i,
    output rkey_t  round_key_o,
    output block_t whiten_in_o,
    output block_t whiten_out_o
);

    key_t   prk_q;
    logic   decrypt_q;
    round_t key_idx;
    key_t   mix_t;
    key_t   mix_sum;
    block_t pre_key;
    block_t post_key;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            decrypt_q <= 1'b0;
        end else if (capture_i) begin
            decrypt_q <= decrypt_i;
        end
    end

    // Pseudorandom key, salted master key
    always_ff @(posedge clk) begin
        if (capture_i) begin
            prk_q <= key_i ^ HKDF_SALT;
        end
    end

    // Decryption walks the round keys backwards
    assign key_idx = decrypt_q ? (ROUND_W'(ROUNDS - 1) - round_i) : round_i;

    always_comb begin
        mix_t   = prk_q ^ (KEY_W'(key_idx) * PHI_256);
        // Add to itself rotated left by 32
        mix_sum = mix_t + {mix_t[KEY_W-33:0], mix_t[KEY_W-1:KEY_W-32]};
    end

    assign round_key_o = mix_sum[RKEY_W-1:0] ^ mix_sum[KEY_W-1:RKEY_W];

    // ============================================================
    // Whitening keys, swapped for decryption
    // ============================================================
    assign pre_key  = prk_q[BLOCK_W-1:0] ^ PRE_WHITEN_CONST[BLOCK_W-1:0];
    assign post_key = prk_q[KEY_W-1:BLOCK_W] ^ POST_WHITEN_CONST[KEY_W-1:BLOCK_W];

    assign whiten_in_o  = decrypt_q ? post_key : pre_key;
    assign whiten_out_o = decrypt_q ? pre_key  : post_key;

endmodule

//--- verilog/feistel48_round_function.sv
// Feistel-48 F-function: key xor, S-box layer, rotate mix and add-rotate-xor
module feistel48_round_function
    import feistel48_pkg::*;
(
    input  half_t right_i,
    input  rkey_t round_key_i,
    output half_t f_o
);

    half_t key_mix;
    half_t sbox_out;
    half_t mix;
    half_t arx;

    always_comb begin
        key_mix = right_i ^ round_key_i[HALF_W-1:0];

        // One S-box per byte
        for (int i = 0; i < HALF_W / 8; i++) begin
            sbox_out[i*8 +: 8] = aes_sbox(key_mix[i*8 +: 8]);
        end

        // Diffusion with right rotations by 7 and 11
        mix = sbox_out
            ^ {sbox_out[6:0], sbox_out[HALF_W-1:7]}
            ^ {sbox_out[10:0], sbox_out[HALF_W-1:11]};

        // Logical shifts here, not rotates
        arx = (mix + PHI_64) ^ (mix << 13) ^ (mix >> 29);
    end

    assign f_o = arx ^ round_key_i[RKEY_W-1:HALF_W];

endmodule

//--- verilog/feistel48_block_state.sv
// Feistel-48 block state: half registers, round update and whitened output register
module feistel48_block_state
    import feistel48_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   load_i,
    input  logic   round_en_i,
    input  logic   finish_i,
    input  block_t block_i,
    input  block_t whiten_in_i,
    input  block_t whiten_out_i,
    input  half_t  f_i,
    output half_t  right_o,
    output block_t block_o
);

    half_t  left_q;
    half_t  right_q;
    block_t block_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            left_q  <= '0;
            right_q <= '0;
            block_q <= '0;
        end else begin
            if (load_i) begin
                // Input whitening
                left_q  <= block_i[BLOCK_W-1:HALF_W] ^ whiten_in_i[BLOCK_W-1:HALF_W];
                right_q <= block_i[HALF_W-1:0] ^ whiten_in_i[HALF_W-1:0];
            end else if (round_en_i) begin
                left_q  <= right_q;
                right_q <= left_q ^ f_i;
            end

            // Final swap, then output whitening
            if (finish_i) begin
                block_q <= {right_q, left_q} ^ whiten_out_i;
            end
        end
    end

    assign right_o = right_q;
    assign block_o = block_q;

endmodule

//--- verilog/feistel48_core.sv
// Feistel-48 cipher core: sequencer, key schedule, F-function and block state
module feistel48_core
    import feistel48_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start_i,
    input  logic   decrypt_i,
    input  key_t   key_i,
    input  block_t block_i,
    output block_t block_o,
    output logic   done_o,
    output logic   busy_o
);

    logic   capture;
    logic   load;
    logic   round_en;
    logic   finish;
    round_t round_idx;
    rkey_t  round_key;
    block_t whiten_in;
    block_t whiten_out;
    half_t  right_half;
    half_t  f_out;

    feistel48_control u_control (
        .clk        (clk),
        .reset      (reset),
        .start_i    (start_i),
        .capture_o  (capture),
        .load_o     (load),
        .round_en_o (round_en),
        .finish_o   (finish),
        .round_o    (round_idx),
        .done_o     (done_o),
        .busy_o     (busy_o)
    );

    feistel48_key_schedule u_key_schedule (
        .clk          (clk),
        .reset        (reset),
        .capture_i    (capture),
        .decrypt_i    (decrypt_i),
        .key_i        (key_i),
        .round_i      (round_idx),
        .round_key_o  (round_key),
        .whiten_in_o  (whiten_in),
        .whiten_out_o (whiten_out)
    );

    feistel48_round_function u_round_function (
        .right_i     (right_half),
        .round_key_i (round_key),
        .f_o         (f_out)
    );

    feistel48_block_state u_block_state (
        .clk          (clk),
        .reset        (reset),
        .load_i       (load),
        .round_en_i   (round_en),
        .finish_i     (finish),
        .block_i      (block_i),
        .whiten_in_i  (whiten_in),
        .whiten_out_i (whiten_out),
        .f_i          (f_out),
        .right_o      (right_half),
        .block_o      (block_o)
    );

endmodule

//--- verification/feistel48_model.svh
// Feistel-48 reference model: S-box from GF(2^8), round keys, F-function, block cipher, LFSR
`ifndef FEISTEL48_MODEL_SVH
`define FEISTEL48_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'd71027;

logic [31:0] lfsr_state;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken, bits land in the low end
function automatic logic [255:0] random_bits(input int n);
    logic [255:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[254:0], lfsr_state[0]};
    end
    return v;
endfunction

// Multiply in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = '0;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            p = p ^ x;
        end
        x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1B) : {x[6:0], 1'b0};
    end
    return p;
endfunction

// AES S-box: inverse as x^254, then the affine map
function automatic logic [7:0] sbox_ref(input logic [7:0] x);
    logic [7:0] inv;
    logic [7:0] pw;
    logic [7:0] rot;
    logic [7:0] s;
    inv = 8'h01;
    pw  = x;
    for (int i = 0; i < 8; i++) begin
        if (i != 0) begin
            inv = gf_mul(inv, pw);
        end
        pw = gf_mul(pw, pw);
    end
    s   = inv ^ 8'h63;
    rot = inv;
    for (int k = 1; k <= 4; k++) begin
        rot = {rot[6:0], rot[7]};
        s   = s ^ rot;
    end
    return s;
endfunction

function automatic rkey_t model_round_key(input key_t prk, input int idx);
    key_t r_wide;
    key_t t;
    key_t sum;
    r_wide = idx;
    t      = prk ^ (r_wide * PHI_256);
    sum    = t + ((t << 32) | (t >> 224));
    return sum[127:0] ^ sum[255:128];
endfunction

function automatic half_t model_f(input half_t r, input rkey_t k);
    half_t x;
    half_t s;
    half_t m;
    half_t a;
    x = r ^ k[63:0];
    for (int b = 0; b < 8; b++) begin
        s[b*8 +: 8] = sbox_ref(x[b*8 +: 8]);
    end
    m = s ^ ((s >> 7) | (s << 57)) ^ ((s >> 11) | (s << 53));
    a = (m + PHI_64) ^ (m << 13) ^ (m >> 29);
    return a ^ k[127:64];
endfunction

// Whole block, decryption reverses the key order and swaps whitening keys
function automatic block_t model_cipher(input key_t key, input block_t blk, input logic dec);
    key_t   prk;
    block_t pre;
    block_t post;
    block_t k_in;
    block_t k_out;
    half_t  l;
    half_t  r;
    half_t  tmp;
    int     idx;
    prk   = key ^ HKDF_SALT;
    pre   = prk[127:0] ^ PRE_WHITEN_CONST[127:0];
    post  = prk[255:128] ^ POST_WHITEN_CONST[255:128];
    k_in  = dec ? post : pre;
    k_out = dec ? pre : post;
    l     = blk[127:64] ^ k_in[127:64];
    r     = blk[63:0] ^ k_in[63:0];
    for (int i = 0; i < ROUNDS; i++) begin
        idx = dec ? (ROUNDS - 1 - i) : i;
        tmp = r;
        r   = l ^ model_f(r, model_round_key(prk, idx));
        l   = tmp;
    end
    return {r, l} ^ k_out;
endfunction

`endif

//--- verification/feistel48_tb.sv
// Feistel-48 testbench: random encrypt and decrypt runs checked against a reference model
module feistel48_tb
    import feistel48_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "feistel48_model.svh"

    localparam int PERIOD_NS   = 8;
    localparam int TIMEOUT_CYC = 100;
    localparam int NUM_VEC     = 8;

    logic   clk;
    logic   reset;
    logic   start_i;
    logic   decrypt_i;
    key_t   key_i;
    block_t block_i;
    block_t block_o;
    logic   done_o;
    logic   busy_o;

    int     value_errors;
    int     timing_errors;
    key_t   keys [NUM_VEC];
    block_t plain [NUM_VEC];
    block_t cipher [NUM_VEC];

    feistel48_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .start_i   (start_i),
        .decrypt_i (decrypt_i),
        .key_i     (key_i),
        .block_i   (block_i),
        .block_o   (block_o),
        .done_o    (done_o),
        .busy_o    (busy_o)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    // ============================================================
    // Protocol checks
    // ============================================================
    // An accepted start holds busy for 50 cycles before a single-cycle done pulse
    assert property (@(posedge clk) disable iff (reset)
        (start_i && !busy_o) |=> (busy_o && !done_o) [*50] ##1 (done_o && !busy_o)
            ##1 !done_o)
    else begin
        timing_errors++;
        $display("busy_o or done_o out of step after an accepted start at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        $rose(done_o) |-> $past(start_i && !busy_o, 51))
    else begin
        timing_errors++;
        $display("done_o rose without a matching accepted start at %0t", $time);
    end

    // Result register only moves when done rises
    assert property (@(posedge clk) disable iff (reset)
        !done_o |-> $stable(block_o))
    else begin
        timing_errors++;
        $display("block_o changed without a done pulse at %0t", $time);
    end

    task automatic check_block(input string what, input block_t exp, input block_t got);
        assert (got === exp)
        else begin
            value_errors++;
            $display("[FAIL] block_o (%s) expected %h got %h", what, exp, got);
        end
    endtask

    // Entered 1 ns after a rising edge, returns 1 ns after the edge that raised done_o
    task automatic run_op(input key_t key, input block_t blk, input logic dec,
                          input logic noise, output block_t result);
        int cycles;
        start_i   = 1'b1;
        decrypt_i = dec;
        key_i     = key;
        block_i   = blk;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        cycles  = 0;
        while (done_o !== 1'b1 && cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            #1;
            cycles++;
            start_i = 1'b0;
            // Competing requests while busy
            if (noise && (cycles == 10 || cycles == 30)) begin
                start_i   = 1'b1;
                decrypt_i = ~dec;
                key_i     = random_bits(KEY_W);
                block_i   = BLOCK_W'(random_bits(BLOCK_W));
            end
        end
        if (done_o !== 1'b1) begin
            timing_errors++;
            $display("Timed out waiting for done_o after %0d cycles", cycles);
        end
        result = block_o;
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        block_t result;
        block_t held;
        clk           = 1'b0;
        reset         = 1'b1;
        start_i       = 1'b0;
        decrypt_i     = 1'b0;
        key_i         = '0;
        block_i       = '0;
        value_errors  = 0;
        timing_errors = 0;
        lfsr_state    = LFSR_SEED;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        assert (done_o === 1'b0 && busy_o === 1'b0)
        else begin
            timing_errors++;
            $display("done_o or busy_o not low after reset");
        end
        check_block("after reset", '0, block_o);

        // Encryption runs with vector 0 all zero
        for (int i = 0; i < NUM_VEC; i++) begin
            keys[i]  = (i == 0) ? '0 : random_bits(KEY_W);
            plain[i] = (i == 0) ? '0 : BLOCK_W'(random_bits(BLOCK_W));
            run_op(keys[i], plain[i], 1'b0, i == 3, result);
            cipher[i] = result;
            check_block("encrypt", model_cipher(keys[i], plain[i], 1'b0), result);
        end

        held = block_o;
        repeat (5) @(posedge clk);
        #1;
        check_block("held while idle", held, block_o);

        // Round trip back to the plaintext
        for (int i = 0; i < NUM_VEC; i++) begin
            run_op(keys[i], cipher[i], 1'b1, i == 5, result);
            check_block("decrypt to plaintext", plain[i], result);
            check_block("decrypt model", model_cipher(keys[i], cipher[i], 1'b1), result);
            if (i == 2) begin
                repeat (3) @(posedge clk);
                #1;
            end
        end

        repeat (3) @(posedge clk);
        #1;
        $display("Error counts: value %0d, timing %0d", value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+verification
verilog/feistel48_pkg.sv
verilog/feistel48_control.sv
verilog/feistel48_key_schedule.sv
verilog/feistel48_round_function.sv
verilog/feistel48_block_state.sv
verilog/feistel48_core.sv
verification/feistel48_tb.sv

//--- Bender.yml
package:
  name: feistel48

sources:
  - files:
      - verilog/feistel48_pkg.sv
      - verilog/feistel48_control.sv
      - verilog/feistel48_key_schedule.sv
      - verilog/feistel48_round_function.sv
      - verilog/feistel48_block_state.sv
      - verilog/feistel48_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/feistel48_tb.sv
